// ==== src.f ====
+incdir+common
common/wb_pkg.sv
design/gpr_file.sv
design/csr_file.sv
design/pc_reg.sv
design/wbu.sv
design/wb_top.sv
testbench/tb_wb_top.sv

// ==== testbench/tb_wb_top.sv ====
`timescale 1ns/10ps

`include "wb_params.svh"

module tb_wb_top;
  import wb_pkg::*;

  localparam int RUN_LEN        = 2000;
  localparam int TIMEOUT_CYCLES = RUN_LEN + RUN_LEN / 4; // reset and sweep fit in the margin.

  logic      clock;
  logic      reset;
  logic      i_valid;
  logic      i_wen;
  reg_addr_t i_rd_addr;
  logic      i_csr_wen;
  csr_addr_t i_csr_addr;
  logic      i_brch;
  logic      i_jal;
  logic      i_jalr;
  logic      i_ecall;
  logic      i_mret;
  logic      i_ebreak;
  word_t     i_pc;
  word_t     i_pc_next;
  word_t     i_res;
  reg_addr_t i_rs1_addr;
  reg_addr_t i_rs2_addr;
  csr_addr_t i_csr_raddr;
  word_t     o_rs1_data;
  word_t     o_rs2_data;
  word_t     o_csr_rdata;
  word_t     o_pc;
  logic      o_pc_update;
  logic      o_commit;
  logic      o_halt;

  // reference model state.
  word_t m_regs [0:31];
  word_t m_mtvec;
  word_t m_mepc;
  word_t m_mcause;
  word_t m_pc;
  logic  m_commit;
  logic  m_update;
  word_t m_target;
  logic  m_halt;

  logic [31:0] lfsr_state = 32'd97541;
  int          cycle_count;

  wb_top i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    if (reset) begin
      cycle_count = 0;
    end else begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
        $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on timeout");
      end
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic csr_addr_t pick_csr();
    logic [1:0] sel;
    sel = 2'(rand_bits(2));
    case (sel)
      2'd0:    return `WB_CSR_MTVEC;
      2'd1:    return `WB_CSR_MEPC;
      2'd2:    return `WB_CSR_MCAUSE;
      default: return csr_addr_t'(rand_bits(12)); // mostly unknown csrs.
    endcase
  endfunction

  function automatic word_t model_csr(input csr_addr_t addr);
    case (addr)
      `WB_CSR_MTVEC:  return m_mtvec;
      `WB_CSR_MEPC:   return m_mepc;
      `WB_CSR_MCAUSE: return m_mcause;
      default:        return '0;
    endcase
  endfunction

  task automatic stop_on_error();
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic clear_inputs();
    i_valid     = 1'b0;
    i_wen       = 1'b0;
    i_rd_addr   = '0;
    i_csr_wen   = 1'b0;
    i_csr_addr  = '0;
    i_brch      = 1'b0;
    i_jal       = 1'b0;
    i_jalr      = 1'b0;
    i_ecall     = 1'b0;
    i_mret      = 1'b0;
    i_ebreak    = 1'b0;
    i_pc        = '0;
    i_pc_next   = '0;
    i_res       = '0;
    i_rs1_addr  = '0;
    i_rs2_addr  = '0;
    i_csr_raddr = '0;
  endtask

  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_mtvec  = '0;
    m_mepc   = '0;
    m_mcause = '0;
    m_pc     = `WB_RESET_PC;
    m_commit = 1'b0;
    m_update = 1'b0;
    m_target = '0;
    m_halt   = 1'b0;
  endtask

  task automatic drive_random();
    logic [2:0] kind;
    clear_inputs();
    i_valid = (rand_bits(3) != 0);
    kind = 3'(rand_bits(3));
    case (kind)
      3'd1: i_brch = 1'b1;
      3'd2: begin
        i_jal = 1'b1;
        i_wen = (rand_bits(1) != 0);
      end
      3'd3: begin
        i_jalr = 1'b1;
        i_wen  = (rand_bits(1) != 0);
      end
      3'd4: i_csr_wen = 1'b1;
      3'd5: begin
        i_ecall   = 1'b1;
        i_csr_wen = (rand_bits(1) != 0); // trap against a software write.
      end
      3'd6: i_mret = 1'b1;
      3'd7: begin
        if (rand_bits(6) == 0) begin
          i_ebreak = 1'b1;
        end else begin
          i_wen = (rand_bits(1) != 0);
        end
      end
      default: i_wen = (rand_bits(1) != 0);
    endcase
    i_rd_addr   = reg_addr_t'(rand_bits(5));
    i_csr_addr  = pick_csr();
    i_pc        = rand_bits(32);
    i_pc_next   = rand_bits(32);
    i_res       = rand_bits(32);
    i_rs1_addr  = reg_addr_t'(rand_bits(5));
    i_rs2_addr  = reg_addr_t'(rand_bits(5));
    i_csr_raddr = pick_csr();
  endtask

  task automatic check_outputs();
    check_value("o_rs1_data", o_rs1_data, m_regs[i_rs1_addr]);
    check_value("o_rs2_data", o_rs2_data, m_regs[i_rs2_addr]);
    check_value("o_csr_rdata", o_csr_rdata, model_csr(i_csr_raddr));
    check_value("o_pc", o_pc, m_pc);
    check_value("o_commit", {31'b0, o_commit}, {31'b0, m_commit});
    check_value("o_pc_update", {31'b0, o_pc_update}, {31'b0, m_update});
    check_value("o_halt", {31'b0, o_halt}, {31'b0, m_halt});
  endtask

  // advances the model by one rising edge with the inputs now driven.
  task automatic step_model();
    logic  accept;
    logic  taken;
    logic  redirect;
    word_t target;
    accept   = i_valid && !m_halt && !m_update;
    taken    = i_brch && i_res[0];
    redirect = i_jal || i_jalr || taken || i_ecall || i_mret;
    if (i_jal || i_jalr || taken) begin
      target = i_pc_next;
    end else if (i_ecall) begin
      target = m_mtvec;
    end else if (i_mret) begin
      target = m_mepc;
    end else begin
      target = '0;
    end
    if (m_commit) begin
      m_pc = m_update ? m_target : m_pc + 32'd4;
    end
    if (accept && i_wen && (i_rd_addr != 0)) begin
      m_regs[i_rd_addr] = i_res;
    end
    if (accept && i_csr_wen && (i_csr_addr == `WB_CSR_MTVEC)) begin
      m_mtvec = i_res;
    end
    if (accept && i_ecall) begin
      m_mepc   = i_pc;
      m_mcause = 32'd11;
    end else if (accept && i_csr_wen) begin
      if (i_csr_addr == `WB_CSR_MEPC) m_mepc = i_res;
      if (i_csr_addr == `WB_CSR_MCAUSE) m_mcause = i_res;
    end
    m_commit = accept;
    m_update = accept && redirect;
    m_target = accept ? target : '0;
    m_halt   = m_halt || (accept && i_ebreak);
  endtask

  task automatic apply_reset();
    @(negedge clock);
    clear_inputs();
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    reset_model();
  endtask

  // every register and csr should read zero right after reset.
  task automatic sweep_after_reset();
    for (int i = 0; i < 16; i++) begin
      @(negedge clock);
      clear_inputs();
      i_rs1_addr = reg_addr_t'(2 * i);
      i_rs2_addr = reg_addr_t'(2 * i + 1);
      case (i % 4)
        0:       i_csr_raddr = `WB_CSR_MTVEC;
        1:       i_csr_raddr = `WB_CSR_MEPC;
        2:       i_csr_raddr = `WB_CSR_MCAUSE;
        default: i_csr_raddr = 12'h300;
      endcase
      @(posedge clock);
      check_outputs();
      step_model();
    end
  endtask

  task automatic run_test();
    apply_reset();
    sweep_after_reset();
    for (int n = 0; n < RUN_LEN; n++) begin
      @(negedge clock);
      drive_random();
      @(posedge clock);
      check_outputs();
      step_model();
    end
  endtask

  initial begin
    reset = 1'b1;
    clear_inputs();
    reset_model();
    run_test();
    $display("first run done, halt %0d", m_halt);
    run_test(); // second pass behind a fresh reset.
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== design/wb_top.sv ====
`timescale 1ns/10ps

module wb_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               i_valid,
  input  logic               i_wen,
  input  wb_pkg::reg_addr_t  i_rd_addr,
  input  logic               i_csr_wen,
  input  wb_pkg::csr_addr_t  i_csr_addr,
  input  logic               i_brch,
  input  logic               i_jal,
  input  logic               i_jalr,
  input  logic               i_ecall,
  input  logic               i_mret,
  input  logic               i_ebreak,
  input  wb_pkg::word_t      i_pc,
  input  wb_pkg::word_t      i_pc_next,
  input  wb_pkg::word_t      i_res,
  input  wb_pkg::reg_addr_t  i_rs1_addr,
  input  wb_pkg::reg_addr_t  i_rs2_addr,
  input  wb_pkg::csr_addr_t  i_csr_raddr,
  output wb_pkg::word_t      o_rs1_data,
  output wb_pkg::word_t      o_rs2_data,
  output wb_pkg::word_t      o_csr_rdata,
  output wb_pkg::word_t      o_pc,
  output logic               o_pc_update,
  output logic               o_commit,
  output logic               o_halt
);
  import wb_pkg::*;

  logic      rd_wen;
  reg_addr_t rd_addr;
  word_t     rd_wdata;
  logic      csr_wen;
  csr_addr_t csr_waddr;
  word_t     csr_wdata;
  logic      trap;
  word_t     trap_pc;
  word_t     mtvec;
  word_t     mepc;
  word_t     pc_next;

  wbu u_wbu (
    .clock       (clock),
    .reset       (reset),
    .i_valid     (i_valid),
    .i_wen       (i_wen),
    .i_rd_addr   (i_rd_addr),
    .i_csr_wen   (i_csr_wen),
    .i_csr_addr  (i_csr_addr),
    .i_brch      (i_brch),
    .i_jal       (i_jal),
    .i_jalr      (i_jalr),
    .i_ecall     (i_ecall),
    .i_mret      (i_mret),
    .i_ebreak    (i_ebreak),
    .i_pc        (i_pc),
    .i_pc_next   (i_pc_next),
    .i_res       (i_res),
    .i_mtvec     (mtvec),
    .i_mepc      (mepc),
    .o_rd_wen    (rd_wen),
    .o_rd_addr   (rd_addr),
    .o_rd_wdata  (rd_wdata),
    .o_csr_wen   (csr_wen),
    .o_csr_addr  (csr_waddr),
    .o_csr_wdata (csr_wdata),
    .o_trap      (trap),
    .o_trap_pc   (trap_pc),
    .o_commit    (o_commit),
    .o_pc_update (o_pc_update),
    .o_pc_next   (pc_next),
    .o_halt      (o_halt)
  );

  gpr_file u_gpr_file (
    .clock    (clock),
    .reset    (reset),
    .i_wen    (rd_wen),
    .i_waddr  (rd_addr),
    .i_wdata  (rd_wdata),
    .i_raddr1 (i_rs1_addr),
    .i_raddr2 (i_rs2_addr),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  csr_file u_csr_file (
    .clock     (clock),
    .reset     (reset),
    .i_wen     (csr_wen),
    .i_waddr   (csr_waddr),
    .i_wdata   (csr_wdata),
    .i_trap    (trap),
    .i_trap_pc (trap_pc),
    .i_raddr   (i_csr_raddr),
    .o_rdata   (o_csr_rdata),
    .o_mtvec   (mtvec),
    .o_mepc    (mepc)
  );

  pc_reg u_pc_reg (
    .clock       (clock),
    .reset       (reset),
    .i_commit    (o_commit),
    .i_pc_update (o_pc_update),
    .i_pc_next   (pc_next),
    .o_pc        (o_pc)
  );

endmodule

// ==== design/wbu.sv ====
`timescale 1ns/10ps

module wbu (
  input  logic               clock,
  input  logic               reset,
  input  logic               i_valid,
  input  logic               i_wen,
  input  wb_pkg::reg_addr_t  i_rd_addr,
  input  logic               i_csr_wen,
  input  wb_pkg::csr_addr_t  i_csr_addr,
  input  logic               i_brch,
  input  logic               i_jal,
  input  logic               i_jalr,
  input  logic               i_ecall,
  input  logic               i_mret,
  input  logic               i_ebreak,
  input  wb_pkg::word_t      i_pc,
  input  wb_pkg::word_t      i_pc_next,
  input  wb_pkg::word_t      i_res,
  input  wb_pkg::word_t      i_mtvec,
  input  wb_pkg::word_t      i_mepc,
  output logic               o_rd_wen,
  output wb_pkg::reg_addr_t  o_rd_addr,
  output wb_pkg::word_t      o_rd_wdata,
  output logic               o_csr_wen,
  output wb_pkg::csr_addr_t  o_csr_addr,
  output wb_pkg::word_t      o_csr_wdata,
  output logic               o_trap,
  output wb_pkg::word_t      o_trap_pc,
  output logic               o_commit,
  output logic               o_pc_update,
  output wb_pkg::word_t      o_pc_next,
  output logic               o_halt
);
  import wb_pkg::*;

  logic  accept;
  logic  taken;
  logic  redirect;
  word_t target;

  // the cycle right after a redirect carries the wrong-path instruction.
  assign accept   = i_valid && !o_halt && !o_pc_update;
  assign taken    = i_brch && i_res[0]; // branch condition rides on bit 0.
  assign redirect = i_jal || i_jalr || taken || i_ecall || i_mret;

  assign o_rd_wen    = accept && i_wen;
  assign o_rd_addr   = i_rd_addr;
  assign o_rd_wdata  = i_res;
  assign o_csr_wen   = accept && i_csr_wen;
  assign o_csr_addr  = i_csr_addr;
  assign o_csr_wdata = i_res;
  assign o_trap      = accept && i_ecall;
  assign o_trap_pc   = i_pc;

  always_comb begin
    if (i_jal || i_jalr || taken) begin
      target = i_pc_next;
    end else if (i_ecall) begin
      target = i_mtvec; // trap vector as it stood before this edge.
    end else if (i_mret) begin
      target = i_mepc;
    end else begin
      target = '0;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      o_commit    <= 1'b0;
      o_pc_update <= 1'b0;
      o_pc_next   <= '0;
    end else begin
      o_commit    <= accept;
      o_pc_update <= accept && redirect;
      o_pc_next   <= accept ? target : '0; // zero when nothing redirects.
    end
  end

  // halt is sticky until the next reset.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      o_halt <= 1'b0;
    end else if (accept && i_ebreak) begin
      o_halt <= 1'b1;
    end
  end

endmodule

// ==== design/pc_reg.sv ====
`timescale 1ns/10ps

`include "wb_params.svh"

module pc_reg (
  input  logic           clock,
  input  logic           reset,
  input  logic           i_commit,
  input  logic           i_pc_update,
  input  wb_pkg::word_t  i_pc_next,
  output wb_pkg::word_t  o_pc
);
  import wb_pkg::*;

  word_t pc_seq;

  assign pc_seq = o_pc + 32'd4;

  // moves only on a commit pulse from the write-back unit.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      o_pc <= `WB_RESET_PC;
    end else if (i_commit) begin
      if (i_pc_update) begin
        o_pc <= i_pc_next;
      end else begin
        o_pc <= pc_seq;
      end
    end
  end

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/10ps

`include "wb_params.svh"

module csr_file (
  input  logic               clock,
  input  logic               reset,
  input  logic               i_wen,
  input  wb_pkg::csr_addr_t  i_waddr,
  input  wb_pkg::word_t      i_wdata,
  input  logic               i_trap,
  input  wb_pkg::word_t      i_trap_pc,
  input  wb_pkg::csr_addr_t  i_raddr,
  output wb_pkg::word_t      o_rdata,
  output wb_pkg::word_t      o_mtvec,
  output wb_pkg::word_t      o_mepc
);
  import wb_pkg::*;

  word_t mtvec;
  word_t mepc;
  word_t mcause;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec <= '0;
    end else if (i_wen && (i_waddr == `WB_CSR_MTVEC)) begin
      mtvec <= i_wdata;
    end
  end

  // the trap overrides a software write to mepc or mcause.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
    end else if (i_trap) begin
      mepc   <= i_trap_pc;
      mcause <= `WB_ECALL_CAUSE;
    end else if (i_wen) begin
      if (i_waddr == `WB_CSR_MEPC) begin
        mepc <= i_wdata;
      end
      if (i_waddr == `WB_CSR_MCAUSE) begin
        mcause <= i_wdata;
      end
    end
  end

  always_comb begin
    case (i_raddr)
      `WB_CSR_MTVEC:  o_rdata = mtvec;
      `WB_CSR_MEPC:   o_rdata = mepc;
      `WB_CSR_MCAUSE: o_rdata = mcause;
      default:        o_rdata = '0; // unimplemented csrs read as zero.
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

// ==== design/gpr_file.sv ====
`timescale 1ns/10ps

module gpr_file (
  input  logic               clock,
  input  logic               reset,
  input  logic               i_wen,
  input  wb_pkg::reg_addr_t  i_waddr,
  input  wb_pkg::word_t      i_wdata,
  input  wb_pkg::reg_addr_t  i_raddr1,
  input  wb_pkg::reg_addr_t  i_raddr2,
  output wb_pkg::word_t      o_rdata1,
  output wb_pkg::word_t      o_rdata2
);
  import wb_pkg::*;

  word_t regs [0:31];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata; // x0 is never written.
    end
  end

  // no bypass, a write shows up after the edge.
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== common/wb_pkg.sv ====
package wb_pkg;

  // one machine word: data, address or csr value.
  typedef logic [31:0] word_t;

  // general register index, x0 to x31.
  typedef logic [4:0] reg_addr_t;

  // csr address as carried in the instruction immediate.
  typedef logic [11:0] csr_addr_t;

endpackage

// ==== common/wb_params.svh ====
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// first fetch address after reset.
`define WB_RESET_PC 32'h8000_0000

// machine csr addresses kept by the csr file.
`define WB_CSR_MTVEC  12'h305
`define WB_CSR_MEPC   12'h341
`define WB_CSR_MCAUSE 12'h342

`define WB_ECALL_CAUSE 32'd11 // environment call from m-mode.

`endif
